// ==== list.f ====
source/pcs_pkg.sv
source/pcs_rx_ordered_set.sv
source/pcs_aneg_fsm.sv
source/pcs_tx_encoder.sv
source/pcs_rx_gmii.sv
source/gig_basex_pcs.sv
tests/pcs_checker.sv
tests/tb_gig_basex_pcs.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_gig_basex_pcs -o tb_sim

output="$(./obj_dir/tb_sim)"
echo "$output"

if grep -q "ALL CHECKS PASSED" <<< "$output"; then
	exit 0
fi
exit 1

// ==== source/gig_basex_pcs.sv ====
`timescale 1ns/1ns

module gig_basex_pcs
	import pcs_pkg::*;
#(
	parameter logic [31:0] link_timer_basex = 32'd1249999,
	parameter logic [31:0] link_timer_sgmii = 32'd249
) (
	input  wire         clk_125mhz,
	input  wire         rst_n,
	// High for SGMII, low for 1000BASE-X
	input  wire         sgmii_mode,
	input  wire         rx_valid,
	input  wire         rx_is_ctl,
	input  wire  [7:0]  rx_data,
	output logic        link_up,
	output link_speed_t link_speed,
	output logic        gmii_rx_en,
	output logic        gmii_rx_er,
	output logic [7:0]  gmii_rx_data,
	output logic        gmii_rx_dvalid,
	output logic        tx_is_ctl,
	output logic [7:0]  tx_data,
	output logic        tx_force_neg_disparity
);

	////////////////////////////////////////////////////////////
	// Negotiation path

	logic        cfg_valid;
	logic [15:0] cfg_word;
	logic        idle_match;
	tx_mode_t    tx_mode;
	logic [15:0] tx_config_word;

	pcs_rx_ordered_set u_rx_set (
		.clk_125mhz (clk_125mhz),
		.rst_n      (rst_n),
		.rx_valid   (rx_valid),
		.rx_is_ctl  (rx_is_ctl),
		.rx_data    (rx_data),
		.cfg_valid  (cfg_valid),
		.cfg_word   (cfg_word),
		.idle_match (idle_match)
	);

	pcs_aneg_fsm #(
		.link_timer_basex (link_timer_basex),
		.link_timer_sgmii (link_timer_sgmii)
	) u_aneg (
		.clk_125mhz     (clk_125mhz),
		.rst_n          (rst_n),
		.sgmii_mode     (sgmii_mode),
		.cfg_valid      (cfg_valid),
		.cfg_word       (cfg_word),
		.idle_match     (idle_match),
		.link_up        (link_up),
		.link_speed     (link_speed),
		.tx_mode        (tx_mode),
		.tx_config_word (tx_config_word)
	);

	pcs_tx_encoder u_tx (
		.clk_125mhz             (clk_125mhz),
		.rst_n                  (rst_n),
		.tx_mode                (tx_mode),
		.tx_config_word         (tx_config_word),
		.tx_is_ctl              (tx_is_ctl),
		.tx_data                (tx_data),
		.tx_force_neg_disparity (tx_force_neg_disparity)
	);

	////////////////////////////////////////////////////////////
	// Frame receive path

	pcs_rx_gmii u_rx_gmii (
		.clk_125mhz     (clk_125mhz),
		.rst_n          (rst_n),
		.rx_valid       (rx_valid),
		.rx_is_ctl      (rx_is_ctl),
		.rx_data        (rx_data),
		.gmii_rx_en     (gmii_rx_en),
		.gmii_rx_er     (gmii_rx_er),
		.gmii_rx_data   (gmii_rx_data),
		.gmii_rx_dvalid (gmii_rx_dvalid)
	);

endmodule

// ==== source/pcs_aneg_fsm.sv ====
`timescale 1ns/1ns

module pcs_aneg_fsm
	import pcs_pkg::*;
#(
	parameter logic [31:0] link_timer_basex = 32'd1249999,
	parameter logic [31:0] link_timer_sgmii = 32'd249
) (
	input  wire         clk_125mhz,
	input  wire         rst_n,
	input  wire         sgmii_mode,
	input  wire         cfg_valid,
	input  wire  [15:0] cfg_word,
	input  wire         idle_match,
	output logic        link_up,
	output link_speed_t link_speed,
	output tx_mode_t    tx_mode,
	output logic [15:0] tx_config_word
);

	// Our ability words
	localparam logic [15:0] ability_basex = 16'h0020;
	localparam logic [15:0] ability_sgmii = 16'h4000;

	aneg_state_t state;

	// Link timer, idle at zero, runs while nonzero
	logic [31:0] link_timer;
	logic [31:0] timer_target;
	logic        timer_done;

	// Three deep match filter
	logic [15:0] cfg_q;
	logic [15:0] cfg_q2;
	logic        cfg_match;
	logic        partner_reset;

	// 10 ms for 1000BASE-X, 2 us for SGMII at full length
	assign timer_target = sgmii_mode ? link_timer_sgmii : link_timer_basex;
	assign timer_done   = (link_timer == timer_target);

	// Partner restarted its own negotiation
	assign partner_reset = cfg_match && (cfg_q == 16'h0000);

	// Idles only once we are done with the /C/ exchange
	assign tx_mode = ((state == ANEG_IDLE_DETECT) || (state == ANEG_LINK_OK)) ?
		TX_MODE_IDLE : TX_MODE_CONFIG;

	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			state          <= ANEG_ENABLE;
			link_timer     <= 32'd0;
			link_up        <= 1'b0;
			link_speed     <= LINK_SPEED_1000M;
			tx_config_word <= 16'h0000;
			cfg_q          <= 16'h0000;
			cfg_q2         <= 16'h0000;
			cfg_match      <= 1'b0;
		end else begin

			////////////////////////////////////////////////////////////
			// Timer and match filter

			if (link_timer != 32'd0)
				link_timer <= link_timer + 32'd1;
			if (timer_done)
				link_timer <= 32'd0;

			// Gigabit only in 1000BASE-X
			if (!sgmii_mode)
				link_speed <= LINK_SPEED_1000M;

			if (cfg_valid) begin
				cfg_q     <= cfg_word;
				cfg_q2    <= cfg_q;
				cfg_match <= (cfg_q == cfg_word) && (cfg_q2 == cfg_word);
			end

			////////////////////////////////////////////////////////////
			// Negotiation states

			case (state)
				ANEG_ENABLE: begin
					tx_config_word <= 16'h0000;
					link_timer     <= 32'd1;
					state          <= ANEG_RESTART;
				end

				// Send zeros for one timer period, then advertise
				ANEG_RESTART: begin
					if (timer_done) begin
						tx_config_word <= sgmii_mode ? ability_sgmii : ability_basex;
						state          <= ANEG_ABILITY_DETECT;
					end
				end

				ANEG_ABILITY_DETECT: begin
					if (cfg_match && (cfg_q != 16'h0000)) begin
						// Need three fresh words for the ACK
						cfg_q     <= 16'h0000;
						cfg_q2    <= 16'h0000;
						cfg_match <= 1'b0;
						state     <= ANEG_ACK_DETECT;
						// No full duplex from the partner
						if (sgmii_mode && !cfg_q[12])
							state <= ANEG_ENABLE;
						if (!sgmii_mode && !cfg_q[5])
							state <= ANEG_ENABLE;
					end
					// Partner without negotiation, idles only
					if (idle_match) begin
						link_up    <= 1'b1;
						link_timer <= 32'd1;
						state      <= ANEG_LINK_OK;
					end
				end

				ANEG_ACK_DETECT: begin
					tx_config_word[14] <= 1'b1;
					if (cfg_match && cfg_q[14]) begin
						// Speed code in bits 11:10, 3 is reserved
						if (sgmii_mode) begin
							case (cfg_q[11:10])
								2'd0:    link_speed <= LINK_SPEED_10M;
								2'd1:    link_speed <= LINK_SPEED_100M;
								default: link_speed <= LINK_SPEED_1000M;
							endcase
						end
						link_timer <= 32'd1;
						state      <= ANEG_COMPLETE_ACK;
					end
					if (partner_reset)
						state <= ANEG_ENABLE;
				end

				ANEG_COMPLETE_ACK: begin
					if (timer_done) begin
						if (cfg_match && cfg_q[14]) begin
							link_timer <= 32'd1;
							state      <= ANEG_IDLE_DETECT;
						end else begin
							state <= ANEG_ENABLE;
						end
					end
					if (partner_reset)
						state <= ANEG_ENABLE;
				end

				// Keep waiting in whole timer periods until idles match
				ANEG_IDLE_DETECT: begin
					if (timer_done) begin
						link_timer <= 32'd1;
						if (idle_match) begin
							link_up <= 1'b1;
							state   <= ANEG_LINK_OK;
						end
					end
					if (partner_reset)
						state <= ANEG_ENABLE;
				end

				ANEG_LINK_OK: begin
					if (idle_match)
						link_timer <= 32'd1;
					// Timeout or partner back in negotiation
					if (timer_done || cfg_valid) begin
						link_up <= 1'b0;
						state   <= ANEG_ENABLE;
					end
				end

				default: state <= ANEG_ENABLE;
			endcase
		end
	end

endmodule

// ==== source/pcs_pkg.sv ====
package pcs_pkg;

	////////////////////////////////////////////////////////////
	// Link status and negotiation types

	// Speed as resolved by autonegotiation
	typedef enum logic [1:0] {
		LINK_SPEED_10M   = 2'd0,
		LINK_SPEED_100M  = 2'd1,
		LINK_SPEED_1000M = 2'd2
	} link_speed_t;

	// Clause 37 style negotiation states
	typedef enum logic [2:0] {
		ANEG_ENABLE         = 3'd0,
		ANEG_RESTART        = 3'd1,
		ANEG_ABILITY_DETECT = 3'd2,
		ANEG_ACK_DETECT     = 3'd3,
		ANEG_COMPLETE_ACK   = 3'd4,
		ANEG_IDLE_DETECT    = 3'd5,
		ANEG_LINK_OK        = 3'd6
	} aneg_state_t;

	// Position inside a received /C/ ordered set
	typedef enum logic [1:0] {
		RX_SET_WAIT_K  = 2'd0,
		RX_SET_HEADER  = 2'd1,
		RX_SET_CFG_LO  = 2'd2,
		RX_SET_CFG_HI  = 2'd3
	} rx_set_state_t;

	// What the transmitter sends between frames
	typedef enum logic {
		TX_MODE_CONFIG = 1'b0,
		TX_MODE_IDLE   = 1'b1
	} tx_mode_t;

	////////////////////////////////////////////////////////////
	// Code groups, 8b/10b decoded

	localparam logic [7:0] K_28_5        = 8'hBC;
	localparam logic [7:0] D_21_5        = 8'hB5;
	localparam logic [7:0] D_2_2         = 8'h42;
	localparam logic [7:0] D_16_2        = 8'h50;
	localparam logic [7:0] K_27_7        = 8'hFB;
	localparam logic [7:0] K_29_7        = 8'hFD;
	localparam logic [7:0] K_30_7        = 8'hFE;
	localparam logic [7:0] GMII_PREAMBLE = 8'h55;

endpackage

// ==== source/pcs_rx_gmii.sv ====
`timescale 1ns/1ns

module pcs_rx_gmii
	import pcs_pkg::*;
(
	input  wire        clk_125mhz,
	input  wire        rst_n,
	input  wire        rx_valid,
	input  wire        rx_is_ctl,
	input  wire  [7:0] rx_data,
	output logic       gmii_rx_en,
	output logic       gmii_rx_er,
	output logic [7:0] gmii_rx_data,
	output logic       gmii_rx_dvalid
);

	logic is_sop;
	logic is_eop;
	logic is_err;

	assign is_sop = rx_is_ctl && (rx_data == K_27_7);
	assign is_eop = rx_is_ctl && (rx_data == K_29_7);
	assign is_err = rx_is_ctl && (rx_data == K_30_7);

	////////////////////////////////////////////////////////////
	// Frame delimiters

	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			gmii_rx_en     <= 1'b0;
			gmii_rx_er     <= 1'b0;
			gmii_rx_dvalid <= 1'b0;
		end else begin
			// No valid group, no byte this cycle
			gmii_rx_dvalid <= rx_valid;
			if (rx_valid) begin
				if (!gmii_rx_en) begin
					if (is_sop) begin
						gmii_rx_en <= 1'b1;
						gmii_rx_er <= 1'b0;
					end
				end else if (is_eop) begin
					gmii_rx_en <= 1'b0;
					gmii_rx_er <= 1'b0;
				end else if (is_err) begin
					gmii_rx_er <= 1'b1;
				end
			end
		end
	end

	// /S/ stands in for the first preamble byte
	always_ff @(posedge clk_125mhz) begin
		if (rx_valid) begin
			if (!gmii_rx_en && is_sop)
				gmii_rx_data <= GMII_PREAMBLE;
			else if (gmii_rx_en && !rx_is_ctl)
				gmii_rx_data <= rx_data;
		end
	end

endmodule

// ==== source/pcs_rx_ordered_set.sv ====
`timescale 1ns/1ns

module pcs_rx_ordered_set
	import pcs_pkg::*;
(
	input  wire         clk_125mhz,
	input  wire         rst_n,
	input  wire         rx_valid,
	input  wire         rx_is_ctl,
	input  wire  [7:0]  rx_data,
	output logic        cfg_valid,
	output logic [15:0] cfg_word,
	output logic        idle_match
);

	rx_set_state_t set_state;

	// Low byte of the set in progress
	logic [7:0] cfg_lo;

	// Idle tracker
	logic       last_was_comma;
	logic [1:0] idle_count;

	// Decoded group types
	logic is_comma;
	logic is_cfg_header;
	logic is_idle_data;

	assign is_comma      = rx_is_ctl && (rx_data == K_28_5);
	assign is_cfg_header = !rx_is_ctl && ((rx_data == D_21_5) || (rx_data == D_2_2));
	assign is_idle_data  = !rx_is_ctl && (rx_data == D_16_2);

	////////////////////////////////////////////////////////////
	// /C1/ and /C2/ parser

	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			set_state <= RX_SET_WAIT_K;
			cfg_valid <= 1'b0;
		end else begin
			cfg_valid <= 1'b0;
			if (rx_valid) begin
				case (set_state)
					RX_SET_WAIT_K: begin
						if (is_comma)
							set_state <= RX_SET_HEADER;
					end
					// D21.5 or D2.2, no check that they alternate
					RX_SET_HEADER: begin
						if (is_cfg_header)
							set_state <= RX_SET_CFG_LO;
						else if (!is_comma)
							set_state <= RX_SET_WAIT_K;
					end
					RX_SET_CFG_LO: begin
						if (is_comma)
							set_state <= RX_SET_HEADER;
						else if (rx_is_ctl)
							set_state <= RX_SET_WAIT_K;
						else
							set_state <= RX_SET_CFG_HI;
					end
					// Fourth group completes the word
					RX_SET_CFG_HI: begin
						if (is_comma) begin
							set_state <= RX_SET_HEADER;
						end else begin
							set_state <= RX_SET_WAIT_K;
							cfg_valid <= !rx_is_ctl;
						end
					end
					default: set_state <= RX_SET_WAIT_K;
				endcase
			end
		end
	end

	// Word bytes, low byte first on the wire
	always_ff @(posedge clk_125mhz) begin
		if (rx_valid && (set_state == RX_SET_CFG_LO))
			cfg_lo <= rx_data;
		if (rx_valid && (set_state == RX_SET_CFG_HI) && !rx_is_ctl)
			cfg_word <= {rx_data, cfg_lo};
	end

	////////////////////////////////////////////////////////////
	// /I2/ detection

	// Four /I2/ in a row with no /C/ set between them
	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			last_was_comma <= 1'b0;
			idle_count     <= 2'd0;
			idle_match     <= 1'b0;
		end else begin
			if (rx_valid) begin
				last_was_comma <= is_comma;
				if (last_was_comma && is_idle_data) begin
					idle_count <= idle_count + 2'd1;
					if (idle_count == 2'd3)
						idle_match <= 1'b1;
				end
			end
			// A completed /C/ set starts the count again
			if (rx_valid && (set_state == RX_SET_CFG_HI) && !rx_is_ctl) begin
				idle_count <= 2'd0;
				idle_match <= 1'b0;
			end
		end
	end

endmodule

// ==== source/pcs_tx_encoder.sv ====
`timescale 1ns/1ns

module pcs_tx_encoder
	import pcs_pkg::*;
(
	input  wire         clk_125mhz,
	input  wire         rst_n,
	input  tx_mode_t    tx_mode,
	input  wire  [15:0] tx_config_word,
	output logic        tx_is_ctl,
	output logic [7:0]  tx_data,
	output logic        tx_force_neg_disparity
);

	// Free running group counter, one pass is /C1/ then /C2/
	logic [2:0] grp_cnt;

	// Mode of the set on the wire
	tx_mode_t cur_mode;
	tx_mode_t sel_mode;

	// New mode is taken only where both set types start
	assign sel_mode = (grp_cnt[1:0] == 2'd0) ? tx_mode : cur_mode;

	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			grp_cnt                <= 3'd0;
			cur_mode               <= TX_MODE_CONFIG;
			tx_is_ctl              <= 1'b0;
			tx_data                <= 8'h00;
			tx_force_neg_disparity <= 1'b0;
		end else begin
			grp_cnt                <= grp_cnt + 3'd1;
			cur_mode               <= sel_mode;
			tx_is_ctl              <= 1'b0;
			tx_force_neg_disparity <= 1'b0;

			if (sel_mode == TX_MODE_IDLE) begin
				// /I2/ is K28.5 D16.2, comma on even counts
				if (!grp_cnt[0]) begin
					tx_data                <= K_28_5;
					tx_is_ctl              <= 1'b1;
					tx_force_neg_disparity <= 1'b1;
				end else begin
					tx_data <= D_16_2;
				end
			end else begin
				case (grp_cnt[1:0])
					2'd0: begin
						tx_data   <= K_28_5;
						tx_is_ctl <= 1'b1;
					end
					// /C1/ in the first half, /C2/ in the second
					2'd1:    tx_data <= grp_cnt[2] ? D_2_2 : D_21_5;
					2'd2:    tx_data <= tx_config_word[7:0];
					default: tx_data <= tx_config_word[15:8];
				endcase
			end
		end
	end

endmodule

// ==== tests/pcs_checker.sv ====
`timescale 1ns/1ns

module pcs_checker
	import pcs_pkg::*;
(
	input  wire         clk_125mhz,
	input  wire         rst_n,
	input  wire         rx_valid,
	input  wire         rx_is_ctl,
	input  wire  [7:0]  rx_data,
	input  wire         gmii_rx_en,
	input  wire         gmii_rx_er,
	input  wire  [7:0]  gmii_rx_data,
	input  wire         gmii_rx_dvalid,
	input  wire         tx_is_ctl,
	input  wire  [7:0]  tx_data,
	input  wire         tx_force_neg_disparity,
	output logic        tx_idle,
	output logic [15:0] tx_word,
	output logic [31:0] tx_blocks,
	output logic [31:0] error_count,
	output logic [31:0] check_count,
	output logic [31:0] tests_run
);

	// Expected GMII outputs, one cycle behind the received group
	logic        exp_en;
	logic        exp_er;
	logic        exp_dvalid;
	logic [7:0]  exp_data;
	logic        data_known;

	// Transmit stream position and the block being watched
	logic [31:0] tx_pos;
	logic [2:0]  slot;
	logic        comma_force;
	logic [7:0]  word_lo;
	logic [31:0] errors_at_test;

	initial begin
		error_count    = 32'd0;
		check_count    = 32'd0;
		tests_run      = 32'd0;
		errors_at_test = 32'd0;
	end

	////////////////////////////////////////////////////////////
	// Reporting

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count = check_count + 32'd1;
		if (exp !== act) begin
			error_count = error_count + 32'd1;
			$display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	// Failures that have no value to compare
	task automatic problem(input string what);
		check_count = check_count + 32'd1;
		error_count = error_count + 32'd1;
		$display("Error at %0t ns: %s", $time, what);
	endtask

	task automatic test_done(input string name);
		if (error_count == errors_at_test)
			$display("test %s: passed", name);
		else
			$display("test %s: failed with %0d errors", name, error_count - errors_at_test);
		errors_at_test = error_count;
		tests_run      = tests_run + 32'd1;
	endtask

	////////////////////////////////////////////////////////////
	// GMII receive model

	always @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			exp_en     = 1'b0;
			exp_er     = 1'b0;
			exp_dvalid = 1'b0;
			data_known = 1'b0;
			exp_data   = 8'h00;
		end else begin
			compare("gmii_rx_dvalid", {31'd0, exp_dvalid}, {31'd0, gmii_rx_dvalid});
			compare("gmii_rx_en", {31'd0, exp_en}, {31'd0, gmii_rx_en});
			compare("gmii_rx_er", {31'd0, exp_er}, {31'd0, gmii_rx_er});
			if (exp_en && data_known)
				compare("gmii_rx_data", {24'd0, exp_data}, {24'd0, gmii_rx_data});
			// Next expectation from the group on the inputs now
			exp_dvalid = rx_valid;
			if (rx_valid) begin
				if (!exp_en) begin
					if (rx_is_ctl && (rx_data == K_27_7)) begin
						exp_en     = 1'b1;
						exp_er     = 1'b0;
						exp_data   = GMII_PREAMBLE;
						data_known = 1'b1;
					end
				end else if (rx_is_ctl && (rx_data == K_29_7)) begin
					exp_en = 1'b0;
					exp_er = 1'b0;
				end else if (rx_is_ctl && (rx_data == K_30_7)) begin
					exp_er = 1'b1;
				end else if (!rx_is_ctl) begin
					exp_data = rx_data;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Transmit stream model

	// Blocks of four groups, either a /C/ set or two /I2/
	always @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			tx_pos      = 32'd0;
			tx_idle     = 1'b0;
			tx_word     = 16'h0000;
			tx_blocks   = 32'd0;
			comma_force = 1'b0;
			word_lo     = 8'h00;
		end else begin
			// Outputs seen now were made on the previous edge
			if (tx_pos != 32'd0) begin
				slot = tx_pos[2:0] - 3'd1;
				case (slot[1:0])
					2'd0: begin
						compare("tx_is_ctl", 32'd1, {31'd0, tx_is_ctl});
						compare("tx_data", {24'd0, K_28_5}, {24'd0, tx_data});
						comma_force = tx_force_neg_disparity;
					end
					2'd1: begin
						tx_idle = !tx_is_ctl && (tx_data == D_16_2);
						compare("tx_is_ctl", 32'd0, {31'd0, tx_is_ctl});
						compare("tx_force_neg_disparity", 32'd0,
							{31'd0, tx_force_neg_disparity});
						// Forced disparity only on an idle comma
						compare("tx_force_neg_disparity", {31'd0, tx_idle},
							{31'd0, comma_force});
						if (!tx_idle)
							compare("tx_data", {24'd0, slot[2] ? D_2_2 : D_21_5},
								{24'd0, tx_data});
					end
					2'd2: begin
						compare("tx_is_ctl", {31'd0, tx_idle}, {31'd0, tx_is_ctl});
						compare("tx_force_neg_disparity", {31'd0, tx_idle},
							{31'd0, tx_force_neg_disparity});
						if (tx_idle)
							compare("tx_data", {24'd0, K_28_5}, {24'd0, tx_data});
						word_lo = tx_data;
					end
					default: begin
						compare("tx_is_ctl", 32'd0, {31'd0, tx_is_ctl});
						compare("tx_force_neg_disparity", 32'd0,
							{31'd0, tx_force_neg_disparity});
						if (tx_idle)
							compare("tx_data", {24'd0, D_16_2}, {24'd0, tx_data});
						else
							tx_word = {tx_data, word_lo};
						tx_blocks = tx_blocks + 32'd1;
					end
				endcase
			end
			tx_pos = tx_pos + 32'd1;
		end
	end

endmodule

// ==== tests/tb_gig_basex_pcs.sv ====
`timescale 1ns/1ns

module tb_gig_basex_pcs
	import pcs_pkg::*;
;

	// Rough test lengths in clock cycles
	localparam int len_cfg_form = 200;
	localparam int len_basex    = 700;
	localparam int len_frames   = 400;
	localparam int len_loss     = 100;
	localparam int len_sgmii    = 2100;
	localparam int len_no_aneg  = 300;
	localparam int len_total    = len_cfg_form + len_basex + len_frames + len_loss +
		len_sgmii + len_no_aneg;

	logic        clk_125mhz;
	logic        rst_n;
	logic        sgmii_mode;
	logic        rx_valid;
	logic        rx_is_ctl;
	logic [7:0]  rx_data;
	logic        link_up;
	link_speed_t link_speed;
	logic        gmii_rx_en;
	logic        gmii_rx_er;
	logic [7:0]  gmii_rx_data;
	logic        gmii_rx_dvalid;
	logic        tx_is_ctl;
	logic [7:0]  tx_data;
	logic        tx_force_neg_disparity;

	// Checker status
	logic        tx_idle;
	logic [15:0] tx_word;
	logic [31:0] tx_blocks;
	logic [31:0] error_count;
	logic [31:0] check_count;
	logic [31:0] tests_run;

	logic [15:0] lfsr;
	logic        hdr_c2;

	gig_basex_pcs #(
		.link_timer_basex (32'd40),
		.link_timer_sgmii (32'd20)
	) u_dut (
		.clk_125mhz             (clk_125mhz),
		.rst_n                  (rst_n),
		.sgmii_mode             (sgmii_mode),
		.rx_valid               (rx_valid),
		.rx_is_ctl              (rx_is_ctl),
		.rx_data                (rx_data),
		.link_up                (link_up),
		.link_speed             (link_speed),
		.gmii_rx_en             (gmii_rx_en),
		.gmii_rx_er             (gmii_rx_er),
		.gmii_rx_data           (gmii_rx_data),
		.gmii_rx_dvalid         (gmii_rx_dvalid),
		.tx_is_ctl              (tx_is_ctl),
		.tx_data                (tx_data),
		.tx_force_neg_disparity (tx_force_neg_disparity)
	);

	pcs_checker u_chk (
		.clk_125mhz             (clk_125mhz),
		.rst_n                  (rst_n),
		.rx_valid               (rx_valid),
		.rx_is_ctl              (rx_is_ctl),
		.rx_data                (rx_data),
		.gmii_rx_en             (gmii_rx_en),
		.gmii_rx_er             (gmii_rx_er),
		.gmii_rx_data           (gmii_rx_data),
		.gmii_rx_dvalid         (gmii_rx_dvalid),
		.tx_is_ctl              (tx_is_ctl),
		.tx_data                (tx_data),
		.tx_force_neg_disparity (tx_force_neg_disparity),
		.tx_idle                (tx_idle),
		.tx_word                (tx_word),
		.tx_blocks              (tx_blocks),
		.error_count            (error_count),
		.check_count            (check_count),
		.tests_run              (tests_run)
	);

	always #4 clk_125mhz = !clk_125mhz;

	////////////////////////////////////////////////////////////
	// Random numbers

	// Galois LFSR stepped once per bit
	function automatic logic random_bit();
		logic out;
		out  = lfsr[0];
		lfsr = lfsr >> 1;
		if (out)
			lfsr = lfsr ^ 16'hB400;
		return out;
	endfunction

	function automatic logic [7:0] random_bits(input int n);
		logic [7:0] v;
		v = 8'h00;
		for (int i = 0; i < n; i++)
			v = {v[6:0], random_bit()};
		return v;
	endfunction

	// SGMII speed code in bits 11:10
	function automatic link_speed_t speed_for_code(input logic [1:0] code);
		if (code == 2'd0)
			return LINK_SPEED_10M;
		if (code == 2'd1)
			return LINK_SPEED_100M;
		return LINK_SPEED_1000M;
	endfunction

	////////////////////////////////////////////////////////////
	// Link partner

	task automatic put_group(input logic ctl, input logic [7:0] d);
		@(posedge clk_125mhz);
		#1;
		rx_valid  = 1'b1;
		rx_is_ctl = ctl;
		rx_data   = d;
	endtask

	task automatic put_gap();
		@(posedge clk_125mhz);
		#1;
		rx_valid  = 1'b0;
		rx_is_ctl = 1'b0;
		rx_data   = 8'h00;
	endtask

	// /C1/ and /C2/ in turn
	task automatic send_cfg(input logic [15:0] word);
		put_group(1'b1, K_28_5);
		put_group(1'b0, hdr_c2 ? D_2_2 : D_21_5);
		put_group(1'b0, word[7:0]);
		put_group(1'b0, word[15:8]);
		hdr_c2 = !hdr_c2;
	endtask

	task automatic send_idle();
		put_group(1'b1, K_28_5);
		put_group(1'b0, D_16_2);
	endtask

	task automatic apply_reset(input logic sgmii);
		@(posedge clk_125mhz);
		#1;
		rst_n      = 1'b0;
		sgmii_mode = sgmii;
		rx_valid   = 1'b0;
		rx_is_ctl  = 1'b0;
		rx_data    = 8'h00;
		repeat (4) @(posedge clk_125mhz);
		#1;
		rst_n = 1'b1;
	endtask

	// Idles until the link comes up or the pair budget runs out
	task automatic idles_until_link(input int max_pairs);
		int n;
		n = 0;
		while (!link_up && (n < max_pairs)) begin
			send_idle();
			n++;
		end
		if (!link_up)
			u_chk.problem("link_up did not rise while the partner sent idles");
	endtask

	// Frame with a random K30.7 position when asked for
	task automatic send_frame(input int len, input logic with_err);
		int err_pos;
		err_pos = int'(random_bits(3)) % len;
		put_group(1'b1, K_27_7);
		for (int i = 0; i < len; i++) begin
			if (random_bits(3) == 8'd0)
				put_gap();
			if (with_err && (i == err_pos))
				put_group(1'b1, K_30_7);
			put_group(1'b0, random_bits(8));
		end
		put_group(1'b1, K_29_7);
		send_idle();
		send_idle();
	endtask

	////////////////////////////////////////////////////////////
	// Watchdog

	initial begin
		#(len_total * 2 * 8);
		$display("Run timed out after %0t ns, a test did not finish", $time);
		$display("CHECKS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Tests

	initial begin
		int n;
		logic [1:0] code;
		logic [7:0] pick;
		clk_125mhz = 1'b0;
		rst_n      = 1'b0;
		sgmii_mode = 1'b0;
		rx_valid   = 1'b0;
		rx_is_ctl  = 1'b0;
		rx_data    = 8'h00;
		lfsr       = 16'd21;
		hdr_c2     = 1'b0;

		// 1. Configuration sets with a zero word first and our ability after
		apply_reset(1'b0);
		repeat (3) send_cfg(16'h0000);
		if (tx_blocks == 32'd0)
			u_chk.problem("no transmit sets were checked after reset");
		u_chk.compare("tx_config_word", 32'h0, {16'd0, tx_word});
		n = 0;
		while ((tx_word != 16'h0020) && (n < 30)) begin
			send_cfg(16'h0000);
			n++;
		end
		u_chk.compare("tx_config_word", 32'h0020, {16'd0, tx_word});
		u_chk.test_done("cfg_form");

		// 2. 1000BASE-X exchange of ability and ACK followed by idles
		n = 0;
		while (!tx_word[14] && (n < 30)) begin
			send_cfg(16'h0020);
			n++;
		end
		if (!tx_word[14])
			u_chk.problem("no ACK bit in the transmitted word");
		n = 0;
		while (!tx_idle && (n < 40)) begin
			send_cfg(16'h4020);
			n++;
		end
		idles_until_link(200);
		repeat (8) send_idle();
		u_chk.compare("link_speed", {30'd0, LINK_SPEED_1000M}, {30'd0, link_speed});
		u_chk.compare("tx idle mode", 32'd1, {31'd0, tx_idle});
		u_chk.test_done("basex_aneg");

		// 4. Frames on the live link
		for (int f = 0; f < 8; f++)
			send_frame(4 + int'(random_bits(4)), random_bit());
		u_chk.compare("link_up", 32'd1, {31'd0, link_up});
		u_chk.test_done("frame_rx");

		// 5. A /C/ set takes the link down
		send_cfg(16'h4020);
		n = 0;
		while ((link_up || tx_idle) && (n < 8)) begin
			send_idle();
			n++;
		end
		u_chk.compare("link_up", 32'd0, {31'd0, link_up});
		u_chk.compare("tx idle mode", 32'd0, {31'd0, tx_idle});
		u_chk.test_done("link_loss");

		// 3. SGMII speed resolution
		for (int r = 0; r < 3; r++) begin
			apply_reset(1'b1);
			pick = random_bits(2);
			code = pick[1:0];
			while (code == 2'd3) begin
				pick = random_bits(2);
				code = pick[1:0];
			end
			n = 0;
			while (!tx_idle && (n < 60)) begin
				send_cfg(16'h5000 | {4'd0, code, 10'd0});
				n++;
			end
			idles_until_link(200);
			u_chk.compare("link_speed", {30'd0, speed_for_code(code)}, {30'd0, link_speed});
			u_chk.compare("tx_config_word", 32'h4000, {16'd0, tx_word});
		end
		u_chk.test_done("sgmii_speed");

		// 6. Partner sends idles only
		apply_reset(1'b0);
		idles_until_link(100);
		u_chk.compare("link_up", 32'd1, {31'd0, link_up});
		u_chk.compare("link_speed", {30'd0, LINK_SPEED_1000M}, {30'd0, link_speed});
		u_chk.test_done("no_aneg");

		$display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
		if (error_count == 32'd0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
